// File: Bender.yml
package:
  name: lsu

sources:
  - files:
      - verilog/lsu_pkg.sv
      - verilog/lsu_request_gen.sv
      - verilog/lsu_outstanding_ctrl.sv
      - verilog/lsu_rdata_align.sv
      - verilog/lsu_top.sv
  - target: test
    files:
      - test/tb_lsu_mem.sv
      - test/tb_lsu.sv

// File: sources.f
verilog/lsu_pkg.sv
verilog/lsu_request_gen.sv
verilog/lsu_outstanding_ctrl.sv
verilog/lsu_rdata_align.sv
verilog/lsu_top.sv
test/tb_lsu_mem.sv
test/tb_lsu.sv

// File: test/tb_lsu.sv
/* Load/store unit testbench
   Directed and random accesses checked against a shadow byte memory */

`default_nettype none
`timescale 1ns/1ns

module tb_lsu;

  import lsu_pkg::*;

  logic         clk;
  logic         rst_n;
  logic         req_valid;
  lsu_req_t     req;
  logic         req_ready;
  logic         bus_req;
  lsu_bus_req_t bus_pkt;
  logic         bus_gnt;
  logic         bus_rvalid;
  logic [31:0]  bus_rdata;
  logic         res_valid;
  logic [31:0]  res_rdata;
  logic         busy;
  logic         interruptible;

  // Shadow of the memory, updated in issue order
  logic [7:0]   shadow [256];
  lsu_bus_req_t exp_pkt_q [$];
  logic [31:0]  exp_res_q [$];
  logic         exp_load_q [$];
  integer       seed;
  integer       errors;
  integer       checks;
  integer       tests;
  integer       test_errors;
  // Granted transactions without a response yet
  integer       in_flight;
  integer       i;
  integer       s;
  integer       off;
  integer       rsize;
  integer       raddr;

  lsu_top lsu_top_i (
    .clk             (clk),
    .rst_n           (rst_n),
    .req_valid_i     (req_valid),
    .req_i           (req),
    .req_ready_o     (req_ready),
    .bus_req_o       (bus_req),
    .bus_req_pkt_o   (bus_pkt),
    .bus_gnt_i       (bus_gnt),
    .bus_rvalid_i    (bus_rvalid),
    .bus_rdata_i     (bus_rdata),
    .res_valid_o     (res_valid),
    .res_rdata_o     (res_rdata),
    .busy_o          (busy),
    .interruptible_o (interruptible)
  );

  tb_lsu_mem tb_lsu_mem_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .bus_req_i    (bus_req),
    .bus_pkt_i    (bus_pkt),
    .bus_gnt_o    (bus_gnt),
    .bus_rvalid_o (bus_rvalid),
    .bus_rdata_o  (bus_rdata)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  ////////////////////
  // Reference model
  ////////////////////

  function automatic logic [7:0] fill_byte(input logic [7:0] a);
    return (a * 8'h3B) ^ 8'hC6;
  endfunction

  function automatic int size_bytes(input lsu_size_e size);
    int n;
    case (size)
      LSU_BYTE: n = 1;
      LSU_HALF: n = 2;
      default:  n = 4;
    endcase
    return n;
  endfunction

  // Expected load value, gathered byte by byte from the shadow
  function automatic logic [31:0] ref_load(input logic [7:0] addr, input lsu_size_e size,
                                           input logic sext);
    logic [31:0] val;
    int          n;
    int          k;
    val = '0;
    n   = size_bytes(size);
    for (k = 0; k < n; k++) begin
      val[8*k +: 8] = shadow[addr + k];
    end
    if (sext && val[8*n-1]) begin
      for (k = n; k < 4; k++) begin
        val[8*k +: 8] = 8'hFF;
      end
    end
    return val;
  endfunction

  // Bus packet of one part, lanes taken from the byte addresses it covers
  function automatic lsu_bus_req_t ref_pkt(input lsu_req_t r, input logic second);
    lsu_bus_req_t p;
    logic [31:0]  a;
    logic [31:0]  b;
    int           k;
    a       = r.op_a + r.op_b;
    p.addr  = {a[31:2], 2'b00} + (second ? 32'd4 : 32'd0);
    p.we    = r.we;
    p.be    = '0;
    for (k = 0; k < size_bytes(r.size); k++) begin
      b = a + k;
      if ((b[31:2] != a[31:2]) == second) begin
        p.be[b[1:0]] = 1'b1;
      end
    end
    // Lane l carries data byte (l - offset) mod 4
    for (k = 0; k < 4; k++) begin
      p.wdata[8*k +: 8] = r.wdata[8*((k - a[1:0]) & 3) +: 8];
    end
    return p;
  endfunction

  ////////////////////
  // Checks
  ////////////////////

  task automatic check_rdata(input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Mismatch res_rdata_o: got %h expected %h", got, exp);
    end
  endtask

  task automatic check_bus_pkt(input lsu_bus_req_t got, input lsu_bus_req_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Mismatch bus_req_pkt_o: got %h expected %h", got, exp);
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Mismatch %s: got %h expected %h", name, got, exp);
    end
  endtask

  // Sampled mid cycle, each event takes effect at the next rising edge
  always @(negedge clk) begin
    if (rst_n) begin
      if (bus_req && bus_gnt) begin
        in_flight = in_flight + 1;
        if (exp_pkt_q.size() == 0) begin
          errors++;
          $display("Bus grant seen with no access pending");
        end else begin
          check_bus_pkt(bus_pkt, exp_pkt_q.pop_front());
        end
      end
      if (bus_rvalid) begin
        if (in_flight == 0) begin
          errors++;
          $display("Bus response arrived with nothing outstanding");
        end
        in_flight = in_flight - 1;
      end
      if (in_flight > LSU_DEPTH) begin
        errors++;
        $display("More than %0d bus transactions outstanding", LSU_DEPTH);
      end
      // One result per access, in issue order
      if (res_valid) begin
        if (exp_res_q.size() == 0) begin
          errors++;
          $display("Result produced with no access pending");
        end else if (exp_load_q.pop_front()) begin
          check_rdata(res_rdata, exp_res_q.pop_front());
        end else begin
          void'(exp_res_q.pop_front());
        end
      end
    end
  end

  ////////////////////
  // Stimulus
  ////////////////////

  // Entered 5 ns after a rising edge, returns at the same point
  task automatic issue(input logic we, input lsu_size_e size, input logic sext,
                       input logic [31:0] op_a, input logic [31:0] op_b,
                       input logic [31:0] wdata);
    lsu_req_t    r;
    logic [31:0] a;
    int          n;
    int          k;
    int          t;
    r.op_a  = op_a;
    r.op_b  = op_b;
    r.wdata = wdata;
    r.we    = we;
    r.size  = size;
    r.sext  = sext;
    a = op_a + op_b;
    n = size_bytes(size);
    exp_pkt_q.push_back(ref_pkt(r, 1'b0));
    if (a[1:0] + n > 4) begin
      exp_pkt_q.push_back(ref_pkt(r, 1'b1));
    end
    if (we) begin
      for (k = 0; k < n; k++) begin
        shadow[a[7:0] + k] = wdata[8*k +: 8];
      end
      exp_res_q.push_back('0);
      exp_load_q.push_back(1'b0);
    end else begin
      exp_res_q.push_back(ref_load(a[7:0], size, sext));
      exp_load_q.push_back(1'b1);
    end
    req       = r;
    req_valid = 1'b1;
    t = 0;
    @(negedge clk);
    while (!req_ready && t < 200) begin
      t++;
      @(negedge clk);
    end
    if (t >= 200) begin
      errors++;
      $display("Timeout: req_ready_o did not rise within 200 cycles");
    end
    @(posedge clk);
    #5;
    req_valid = 1'b0;
  endtask

  // Drain all responses, then expect the idle status
  task automatic wait_idle();
    int t;
    t = 0;
    @(posedge clk);
    while ((exp_res_q.size() != 0 || exp_pkt_q.size() != 0 || in_flight != 0) && t < 200) begin
      t++;
      @(posedge clk);
    end
    if (t >= 200) begin
      errors++;
      $display("Timeout: responses still missing after 200 cycles");
    end
    @(negedge clk);
    check_flag("busy_o", busy, 1'b0);
    check_flag("interruptible_o", interruptible, 1'b1);
    @(posedge clk);
    #5;
  endtask

  task automatic end_test(input string name);
    tests++;
    if (errors == test_errors) begin
      $display("Test %0d %s: ok", tests, name);
    end else begin
      $display("Test %0d %s: %0d errors", tests, name, errors - test_errors);
    end
    test_errors = errors;
  endtask

  initial begin
    seed        = 32'h3273;
    errors      = 0;
    checks      = 0;
    tests       = 0;
    test_errors = 0;
    in_flight   = 0;
    rst_n       = 1'b0;
    req_valid   = 1'b0;
    req         = '0;
    for (i = 0; i < 256; i++) begin
      shadow[i] = fill_byte(i[7:0]);
    end
    repeat (4) @(posedge clk);
    #5;
    rst_n = 1'b1;

    // Idle status straight out of reset
    @(negedge clk);
    check_flag("busy_o", busy, 1'b0);
    check_flag("interruptible_o", interruptible, 1'b1);
    end_test("reset state");
    @(posedge clk);
    #5;

    // Aligned stores, then loads with both extensions
    issue(1'b1, LSU_WORD, 1'b0, 32'h10, 32'h0, $random(seed));
    issue(1'b1, LSU_HALF, 1'b0, 32'h14, 32'h2, 32'h0000_80F1);
    issue(1'b1, LSU_HALF, 1'b0, 32'h14, 32'h0, 32'h0000_1234);
    issue(1'b1, LSU_BYTE, 1'b0, 32'h18, 32'h1, 32'h0000_00A5);
    issue(1'b1, LSU_BYTE, 1'b0, 32'h18, 32'h3, 32'h0000_0042);
    issue(1'b0, LSU_WORD, 1'b0, 32'h10, 32'h0, 32'h0);
    issue(1'b0, LSU_HALF, 1'b1, 32'h14, 32'h2, 32'h0);
    issue(1'b0, LSU_HALF, 1'b0, 32'h14, 32'h2, 32'h0);
    issue(1'b0, LSU_HALF, 1'b1, 32'h14, 32'h0, 32'h0);
    issue(1'b0, LSU_BYTE, 1'b1, 32'h18, 32'h1, 32'h0);
    issue(1'b0, LSU_BYTE, 1'b0, 32'h18, 32'h1, 32'h0);
    issue(1'b0, LSU_BYTE, 1'b1, 32'h18, 32'h3, 32'h0);
    wait_idle();
    end_test("aligned stores and loads");

    // Every size and offset that fits in one word
    for (s = 0; s < 3; s++) begin
      for (off = 0; off + size_bytes(lsu_size_e'(s)) <= 4; off++) begin
        issue(1'b1, lsu_size_e'(s), 1'b0, 32'h40 + 16 * s, off, $random(seed));
        issue(1'b0, lsu_size_e'(s), 1'b1, 32'h40 + 16 * s, off, 32'h0);
      end
    end
    wait_idle();
    end_test("byte enables and write data");

    // Words at offsets 1 to 3, halfword at offset 3
    for (off = 1; off < 4; off++) begin
      issue(1'b1, LSU_WORD, 1'b0, 32'h60 + 8 * off, off, $random(seed));
      issue(1'b0, LSU_WORD, 1'b0, 32'h60 + 8 * off, off, 32'h0);
    end
    issue(1'b1, LSU_HALF, 1'b0, 32'h90, 32'h3, 32'h0000_9ABC);
    issue(1'b0, LSU_HALF, 1'b1, 32'h90, 32'h3, 32'h0);
    issue(1'b0, LSU_HALF, 1'b0, 32'h90, 32'h3, 32'h0);
    issue(1'b0, LSU_WORD, 1'b0, 32'hA0, 32'h2, 32'h0);
    issue(1'b0, LSU_HALF, 1'b1, 32'hA4, 32'h3, 32'h0);
    wait_idle();
    end_test("split accesses");

    // Random back-to-back accesses, the address sum wraps through op_a
    for (i = 0; i < 40; i++) begin
      raddr = {$random(seed)} % 240;
      rsize = {$random(seed)} % 3;
      issue((i % 5) == 4, lsu_size_e'(rsize), $random(seed), 32'h100,
            raddr - 32'h100, $random(seed));
    end
    wait_idle();
    end_test("back-to-back with bus delays");

    $display("Tests: %0d, checks: %0d, errors: %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: test/tb_lsu_mem.sv
/* Testbench data memory
   Answers the data bus with random grant delays and in-order delayed responses */

`default_nettype none
`timescale 1ns/1ns

module tb_lsu_mem (
  input  wire                   clk,
  input  wire                   rst_n,
  input  wire                   bus_req_i,
  input  lsu_pkg::lsu_bus_req_t bus_pkt_i,
  output logic                  bus_gnt_o,
  output logic                  bus_rvalid_o,
  output logic [31:0]           bus_rdata_o
);

  import lsu_pkg::*;

  logic [31:0] mem [64];
  integer      seed;
  integer      i;
  integer      k;
  // Cycles the current request has waited, and the wait drawn for it
  logic [1:0]  gnt_wait_q;
  logic [1:0]  gnt_delay_q;
  // Response FIFO, never more than LSU_DEPTH entries in use
  logic [31:0] resp_data [4];
  integer      resp_due [4];
  logic [1:0]  wr_p;
  logic [1:0]  rd_p;
  integer      cyc;
  integer      last_due;
  integer      due;
  logic [5:0]  widx;
  logic [31:0] wword;

  // Initial content, every byte a function of its own address
  function automatic logic [7:0] fill_byte(input logic [7:0] a);
    return (a * 8'h3B) ^ 8'hC6;
  endfunction

  initial begin
    seed = 32'h3273;
    for (i = 0; i < 64; i++) begin
      for (k = 0; k < 4; k++) begin
        mem[i][8*k +: 8] = fill_byte(4 * i + k);
      end
    end
  end

  assign bus_gnt_o    = bus_req_i && (gnt_wait_q == gnt_delay_q);
  assign bus_rvalid_o = (wr_p != rd_p) && (resp_due[rd_p] <= cyc);
  assign bus_rdata_o  = resp_data[rd_p];

  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cyc         <= 0;
      last_due    <= 0;
      wr_p        <= 2'd0;
      rd_p        <= 2'd0;
      gnt_wait_q  <= 2'd0;
      gnt_delay_q <= 2'd0;
    end else begin
      cyc <= cyc + 1;
      if (bus_rvalid_o) begin
        rd_p <= rd_p + 2'd1;
      end
      if (bus_gnt_o) begin
        widx  = bus_pkt_i.addr[7:2];
        wword = mem[widx];
        // Store applied lane by lane
        if (bus_pkt_i.we) begin
          for (k = 0; k < 4; k++) begin
            if (bus_pkt_i.be[k]) begin
              wword[8*k +: 8] = bus_pkt_i.wdata[8*k +: 8];
            end
          end
          mem[widx] <= wword;
        end
        // 1 to 3 cycles later, never before the previous response
        due = cyc + 1 + ({$random(seed)} % 3);
        if (due <= last_due) begin
          due = last_due + 1;
        end
        resp_data[wr_p] <= mem[widx];
        resp_due[wr_p]  <= due;
        last_due        <= due;
        wr_p            <= wr_p + 2'd1;
        gnt_wait_q      <= 2'd0;
        gnt_delay_q     <= {$random(seed)} % 3;
      end else if (bus_req_i) begin
        gnt_wait_q <= gnt_wait_q + 2'd1;
      end
    end
  end

endmodule

`default_nettype wire

// File: verilog/lsu_outstanding_ctrl.sv
/* Outstanding transaction control
   Counts bus transactions in flight, drives bus request, ready, busy and interruptible */

`default_nettype none
`timescale 1ns/1ns

module lsu_outstanding_ctrl (
  input  wire  clk,
  input  wire  rst_n,
  input  wire  req_valid_i,
  input  wire  split_i,
  input  wire  bus_gnt_i,
  input  wire  bus_rvalid_i,
  output logic bus_req_o,
  output logic update_o,
  output logic req_ready_o,
  output logic busy_o,
  output logic interruptible_o
);

  import lsu_pkg::*;

  logic [LSU_CNT_W-1:0] cnt_q;
  logic [LSU_CNT_W-1:0] cnt_d;
  // Request seen for at least one cycle without grant
  logic                 wait_q;

  ////////////////////
  // Handshakes
  ////////////////////

  // Responses come no earlier than a cycle after grant, so no rvalid path here
  assign bus_req_o = req_valid_i && (cnt_q < LSU_DEPTH);

  // End of one address phase
  assign update_o = bus_req_o && bus_gnt_i;

  // First half of a split keeps the core waiting
  assign req_ready_o = update_o && !split_i;

  ////////////////////
  // Counter
  ////////////////////

  always_comb begin
    case ({update_o, bus_rvalid_i})
      2'b10:   cnt_d = cnt_q + 1'b1;
      2'b01:   cnt_d = cnt_q - 1'b1;
      default: cnt_d = cnt_q;
    endcase
  end

  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      cnt_q <= '0;
    end else begin
      cnt_q <= cnt_d;
    end
  end

  // A request held ungranted can no longer be withdrawn
  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      wait_q <= 1'b0;
    end else if (update_o) begin
      wait_q <= 1'b0;
    end else if (bus_req_o) begin
      wait_q <= 1'b1;
    end
  end

  assign busy_o          = bus_req_o || (cnt_q != '0);
  assign interruptible_o = !wait_q && (cnt_q == '0);

  a_cnt_max : assert property (
    @(posedge clk) disable iff (!rst_n) cnt_q <= LSU_DEPTH
  );

  // Memory only answers granted transactions
  a_no_orphan_rvalid : assert property (
    @(posedge clk) disable iff (!rst_n) bus_rvalid_i |-> (cnt_q != '0)
  );

  a_req_stable : assert property (
    @(posedge clk) disable iff (!rst_n) bus_req_o && !bus_gnt_i |=> bus_req_o
  );

endmodule

`default_nettype wire

// File: verilog/lsu_pkg.sv
/* Load/store unit package
   Access size encoding, request, bus and load attribute types, depth constants */

`default_nettype none

package lsu_pkg;

  ////////////////////
  // Constants
  ////////////////////

  // Maximum number of bus transactions in flight
  localparam int LSU_DEPTH = 2;
  // Counter must also hold the value LSU_DEPTH itself
  localparam int LSU_CNT_W = $clog2(LSU_DEPTH + 1);

  ////////////////////
  // Types
  ////////////////////

  // Access size, encoded as in the funct3 low bits
  typedef enum logic [1:0] {
    LSU_BYTE = 2'b00,
    LSU_HALF = 2'b01,
    LSU_WORD = 2'b10
  } lsu_size_e;

  // Core request, held stable until accepted
  typedef struct packed {
    logic [31:0] op_a;
    logic [31:0] op_b;
    // Store data, still in register order
    logic [31:0] wdata;
    logic        we;
    lsu_size_e   size;
    logic        sext;
  } lsu_req_t;

  // Address phase of the data bus
  typedef struct packed {
    // Word aligned byte address
    logic [31:0] addr;
    logic        we;
    logic [3:0]  be;
    // Write data already rotated into byte lanes
    logic [31:0] wdata;
  } lsu_bus_req_t;

  // Per transaction info needed when the response returns
  typedef struct packed {
    lsu_size_e  size;
    logic       sext;
    logic       we;
    logic [1:0] offset;
    // Low only for the first part of a split access
    logic       last;
  } lsu_ld_attr_t;

endpackage

`default_nettype wire

// File: verilog/lsu_rdata_align.sv
/* Read data aligner
   Queues load attributes per transaction, merges split reads, aligns and extends */

`default_nettype none
`timescale 1ns/1ns

module lsu_rdata_align (
  input  wire                   clk,
  input  wire                   rst_n,
  input  wire                   update_i,
  input  lsu_pkg::lsu_ld_attr_t attr_i,
  input  wire                   split_i,
  input  wire                   split_phase_i,
  input  wire                   bus_rvalid_i,
  input  wire  [31:0]           bus_rdata_i,
  output logic                  res_valid_o,
  output logic [31:0]           res_rdata_o
);

  import lsu_pkg::*;

  // Attribute queue, one entry per transaction in flight
  lsu_ld_attr_t attr_mem [LSU_DEPTH];
  logic         split_mem [LSU_DEPTH];
  // Depth two, so one bit pointers wrap by themselves
  logic         wr_ptr_q;
  logic         rd_ptr_q;

  lsu_ld_attr_t head;
  logic         head_split;
  // Raw first half of a split load, or the last result
  logic [31:0]  rdata_q;
  logic [63:0]  rdata_full;
  logic [63:0]  rdata_aligned;
  logic [31:0]  rdata_ext;

  always_ff @(posedge clk) begin
    if (update_i) begin
      attr_mem[wr_ptr_q]  <= attr_i;
      split_mem[wr_ptr_q] <= split_i || split_phase_i;
    end
  end

  // Push on grant, pop on response
  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr_q <= 1'b0;
      rd_ptr_q <= 1'b0;
    end else begin
      if (update_i) begin
        wr_ptr_q <= ~wr_ptr_q;
      end
      if (bus_rvalid_i) begin
        rd_ptr_q <= ~rd_ptr_q;
      end
    end
  end

  assign head       = attr_mem[rd_ptr_q];
  assign head_split = split_mem[rd_ptr_q];

  ////////////////////
  // Align and extend
  ////////////////////

  // Low word from the stored first half when split
  assign rdata_full    = head_split ? {bus_rdata_i, rdata_q} : {bus_rdata_i, bus_rdata_i};
  assign rdata_aligned = rdata_full >> (8 * head.offset);

  always_comb begin
    case (head.size)
      LSU_BYTE: rdata_ext = {{24{head.sext && rdata_aligned[7]}}, rdata_aligned[7:0]};
      LSU_HALF: rdata_ext = {{16{head.sext && rdata_aligned[15]}}, rdata_aligned[15:0]};
      default:  rdata_ext = rdata_aligned[31:0];
    endcase
  end

  // Stores leave the buffer untouched
  always_ff @(posedge clk) begin
    if (bus_rvalid_i && !head.we) begin
      if (head_split && !head.last) begin
        rdata_q <= bus_rdata_i;
      end else begin
        rdata_q <= rdata_ext;
      end
    end
  end

  // One result per access, on its last response
  assign res_valid_o = bus_rvalid_i && head.last;
  assign res_rdata_o = rdata_ext;

endmodule

`default_nettype wire

// File: verilog/lsu_request_gen.sv
/* Load/store request generator
   Address add, byte enables, write data rotation and split phase tracking */

`default_nettype none
`timescale 1ns/1ns

module lsu_request_gen (
  input  wire                   clk,
  input  wire                   rst_n,
  input  wire                   req_valid_i,
  input  lsu_pkg::lsu_req_t     req_i,
  input  wire                   update_i,
  output lsu_pkg::lsu_bus_req_t bus_pkt_o,
  output logic                  split_o,
  output logic                  split_phase_o,
  output lsu_pkg::lsu_ld_attr_t attr_o
);

  import lsu_pkg::*;

  logic [31:0] addr;
  logic [1:0]  offset;
  logic [3:0]  be;
  logic [31:0] wdata_rot;
  // Second address phase of a split access in progress
  logic        split_q;

  assign addr   = req_i.op_a + req_i.op_b;
  assign offset = addr[1:0];

  ////////////////////
  // Byte enables
  ////////////////////

  always_comb begin
    case (req_i.size)
      LSU_BYTE: begin
        // One lane selected by offset
        be = 4'b0001 << offset;
      end
      LSU_HALF: begin
        if (!split_q) begin
          case (offset)
            2'b00:   be = 4'b0011;
            2'b01:   be = 4'b0110;
            2'b10:   be = 4'b1100;
            default: be = 4'b1000;
          endcase
        end else begin
          // Upper byte of a halfword at offset 3
          be = 4'b0001;
        end
      end
      default: begin
        if (!split_q) begin
          case (offset)
            2'b00:   be = 4'b1111;
            2'b01:   be = 4'b1110;
            2'b10:   be = 4'b1100;
            default: be = 4'b1000;
          endcase
        end else begin
          // Remaining low lanes in the next word
          case (offset)
            2'b00:   be = 4'b0000;
            2'b01:   be = 4'b0001;
            2'b10:   be = 4'b0011;
            default: be = 4'b0111;
          endcase
        end
      end
    endcase
  end

  // Rotate left by the byte offset for both parts
  always_comb begin
    case (offset)
      2'b00:   wdata_rot = req_i.wdata;
      2'b01:   wdata_rot = {req_i.wdata[23:0], req_i.wdata[31:24]};
      2'b10:   wdata_rot = {req_i.wdata[15:0], req_i.wdata[31:16]};
      default: wdata_rot = {req_i.wdata[7:0], req_i.wdata[31:8]};
    endcase
  end

  // Misaligned word, or halfword crossing the word boundary
  always_comb begin
    split_o = 1'b0;
    if (req_valid_i && !split_q) begin
      if (req_i.size == LSU_WORD && offset != 2'b00) begin
        split_o = 1'b1;
      end else if (req_i.size == LSU_HALF && offset == 2'b11) begin
        split_o = 1'b1;
      end
    end
  end

  // Second part goes to the following word
  assign bus_pkt_o.addr  = split_q ? {addr[31:2], 2'b00} + 32'd4 : {addr[31:2], 2'b00};
  assign bus_pkt_o.we    = req_i.we;
  assign bus_pkt_o.be    = be;
  assign bus_pkt_o.wdata = wdata_rot;

  assign attr_o.size   = req_i.size;
  assign attr_o.sext   = req_i.sext;
  assign attr_o.we     = req_i.we;
  assign attr_o.offset = offset;
  assign attr_o.last   = !split_o;

  // Cleared when the core drops the request
  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      split_q <= 1'b0;
    end else if (!req_valid_i) begin
      split_q <= 1'b0;
    end else if (update_i) begin
      split_q <= split_o;
    end
  end

  assign split_phase_o = split_q;

  // Core holds the split request valid and unchanged through the second phase
  a_split_phase_held : assert property (
    @(posedge clk) disable iff (!rst_n) split_phase_o |-> req_valid_i && $stable(req_i)
  );

endmodule

`default_nettype wire

// File: verilog/lsu_top.sv
/* Load/store unit top level
   Request generator, outstanding control and read aligner between core and data bus */

`default_nettype none
`timescale 1ns/1ns

module lsu_top (
  input  wire                   clk,
  input  wire                   rst_n,
  // Core request
  input  wire                   req_valid_i,
  input  lsu_pkg::lsu_req_t     req_i,
  output logic                  req_ready_o,
  // Data bus address phase
  output logic                  bus_req_o,
  output lsu_pkg::lsu_bus_req_t bus_req_pkt_o,
  input  wire                   bus_gnt_i,
  // Data bus response phase
  input  wire                   bus_rvalid_i,
  input  wire  [31:0]           bus_rdata_i,
  // Write-back
  output logic                  res_valid_o,
  output logic [31:0]           res_rdata_o,
  // Status
  output logic                  busy_o,
  output logic                  interruptible_o
);

  import lsu_pkg::*;

  logic         update;
  logic         split;
  logic         split_phase;
  lsu_ld_attr_t attr;

  lsu_request_gen lsu_request_gen_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .req_valid_i   (req_valid_i),
    .req_i         (req_i),
    .update_i      (update),
    .bus_pkt_o     (bus_req_pkt_o),
    .split_o       (split),
    .split_phase_o (split_phase),
    .attr_o        (attr)
  );

  lsu_outstanding_ctrl lsu_outstanding_ctrl_i (
    .clk             (clk),
    .rst_n           (rst_n),
    .req_valid_i     (req_valid_i),
    .split_i         (split),
    .bus_gnt_i       (bus_gnt_i),
    .bus_rvalid_i    (bus_rvalid_i),
    .bus_req_o       (bus_req_o),
    .update_o        (update),
    .req_ready_o     (req_ready_o),
    .busy_o          (busy_o),
    .interruptible_o (interruptible_o)
  );

  lsu_rdata_align lsu_rdata_align_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .update_i      (update),
    .attr_i        (attr),
    .split_i       (split),
    .split_phase_i (split_phase),
    .bus_rvalid_i  (bus_rvalid_i),
    .bus_rdata_i   (bus_rdata_i),
    .res_valid_o   (res_valid_o),
    .res_rdata_o   (res_rdata_o)
  );

endmodule

`default_nettype wire
